// File: fu_defines.svh
`ifndef FU_DEFINES_SVH
`define FU_DEFINES_SVH

// datapath and address width
`define XLEN 32

// rename tags carried with each op
`define ROBN_W 5
`define PRN_W 6

// in-order queue between operand select and execute
// keep it a power of two, pointers wrap on their own
`define FU_QUEUE_DEPTH 4

// one-bit constants
`define FALSE 1'b0
`define TRUE 1'b1

// markers for illegal select or function codes
`define OPA_BAD_MARK 32'hdead_face
`define OPB_BAD_MARK 32'hface_feed
`define ALU_BAD_MARK 32'hface_beec

`endif

// File: fu_pkg.sv
package fu_pkg;

    // ALU function codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_SLT  = 4'h3,
        ALU_SLTU = 4'h4,
        ALU_OR   = 4'h5,
        ALU_XOR  = 4'h6,
        ALU_SRL  = 4'h7,
        ALU_SLL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_e;

    // operand A source
    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_PC   = 2'h1,
        OPA_IS_ZERO = 2'h2
    } opa_select_e;

    // operand B source, register or one of the immediates
    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_select_e;

    // R/I/S layout
    // I: imm[11:0] is {funct7, rs2}; S: imm[11:0] is {funct7, rd}
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_fields_s;

    // slices shared by the B, U and J immediates
    typedef struct packed {
        logic       sign;
        logic [9:0] imm_30_21;
        logic       imm_20;
        logic [7:0] imm_19_12;
        logic [4:0] imm_11_7;
        logic [6:0] opcode;
    } inst_imm_s;

    // one instruction word, two decodes
    typedef union packed {
        inst_fields_s f;
        inst_imm_s    m;
    } inst_u;

endpackage

// File: operand_select.sv
`timescale 1ns/100ps
`include "fu_defines.svh"

module operand_select (
    input  logic                   valid,
    input  logic [`XLEN-1:0]       inst,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       op1,
    input  logic [`XLEN-1:0]       op2,
    input  fu_pkg::alu_func_e      func,
    input  fu_pkg::opa_select_e    opa_select,
    input  fu_pkg::opb_select_e    opb_select,
    input  logic                   cond_branch,
    input  logic                   uncond_branch,
    input  logic [`ROBN_W-1:0]     robn,
    input  logic [`PRN_W-1:0]      dest_prn,
    output logic                   sel_valid,
    output logic [`XLEN-1:0]       opa,
    output logic [`XLEN-1:0]       opb,
    output fu_pkg::alu_func_e      func_out,
    output logic [2:0]             funct3,
    output logic [`XLEN-1:0]       op1_out,
    output logic [`XLEN-1:0]       op2_out,
    output logic                   cond_out,
    output logic                   uncond_out,
    output logic [`ROBN_W-1:0]     robn_out,
    output logic [`PRN_W-1:0]      dest_prn_out
);

    fu_pkg::inst_u    iw;
    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] s_imm;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] u_imm;
    logic [`XLEN-1:0] j_imm;

    assign iw = inst;

    // sign-extended immediates
    assign i_imm = {{20{iw.m.sign}}, iw.f.funct7, iw.f.rs2};
    assign s_imm = {{20{iw.m.sign}}, iw.f.funct7, iw.f.rd};
    // B: bit 11 sits in inst[7], bit 0 always zero
    assign b_imm = {{20{iw.m.sign}}, iw.m.imm_11_7[0], iw.m.imm_30_21[9:4],
                    iw.m.imm_11_7[4:1], 1'b0};
    // upper 20 bits, low 12 zero
    assign u_imm = {iw.m.sign, iw.m.imm_30_21, iw.m.imm_20, iw.m.imm_19_12, 12'h000};
    assign j_imm = {{12{iw.m.sign}}, iw.m.imm_19_12, iw.m.imm_20, iw.m.imm_30_21, 1'b0};

    // operand A mux
    always_comb begin
        case (opa_select)
            fu_pkg::OPA_IS_RS1:  opa = op1;
            fu_pkg::OPA_IS_PC:   opa = pc;
            fu_pkg::OPA_IS_ZERO: opa = '0;
            default:             opa = `OPA_BAD_MARK;
        endcase
    end

    // operand B mux
    always_comb begin
        case (opb_select)
            fu_pkg::OPB_IS_RS2:   opb = op2;
            fu_pkg::OPB_IS_I_IMM: opb = i_imm;
            fu_pkg::OPB_IS_S_IMM: opb = s_imm;
            fu_pkg::OPB_IS_B_IMM: opb = b_imm;
            fu_pkg::OPB_IS_U_IMM: opb = u_imm;
            fu_pkg::OPB_IS_J_IMM: opb = j_imm;
            default:              opb = `OPB_BAD_MARK;
        endcase
    end

    // branch compare needs funct3 downstream
    assign funct3 = iw.f.funct3;

    // rest rides along to the queue
    assign sel_valid    = valid;
    assign func_out     = func;
    assign op1_out      = op1;
    assign op2_out      = op2;
    assign cond_out     = cond_branch;
    assign uncond_out   = uncond_branch;
    assign robn_out     = robn;
    assign dest_prn_out = dest_prn;

    // issuer must only send legal select codes
    always_comb begin
        if (valid) begin
            assert (opa_select inside {fu_pkg::OPA_IS_RS1, fu_pkg::OPA_IS_PC,
                                       fu_pkg::OPA_IS_ZERO} &&
                    opb_select <= fu_pkg::OPB_IS_J_IMM)
            else $error("operand_select: illegal select code");
        end
    end

endmodule

// File: issue_queue.sv
`timescale 1ns/100ps
`include "fu_defines.svh"

module issue_queue (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  push,
    input  logic [`XLEN-1:0]      opa,
    input  logic [`XLEN-1:0]      opb,
    input  fu_pkg::alu_func_e     func,
    input  logic [2:0]            funct3,
    input  logic [`XLEN-1:0]      op1,
    input  logic [`XLEN-1:0]      op2,
    input  logic                  cond_branch,
    input  logic                  uncond_branch,
    input  logic [`ROBN_W-1:0]    robn,
    input  logic [`PRN_W-1:0]     dest_prn,
    input  logic                  avail,
    output logic                  q_valid,
    output logic [`XLEN-1:0]      q_opa,
    output logic [`XLEN-1:0]      q_opb,
    output fu_pkg::alu_func_e     q_func,
    output logic [2:0]            q_funct3,
    output logic [`XLEN-1:0]      q_op1,
    output logic [`XLEN-1:0]      q_op2,
    output logic                  q_cond_branch,
    output logic                  q_uncond_branch,
    output logic [`ROBN_W-1:0]    q_robn,
    output logic [`PRN_W-1:0]     q_dest_prn,
    output logic                  almost_full
);

    localparam int PTR_W = $clog2(`FU_QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W + 1)'(`FU_QUEUE_DEPTH);
    localparam logic [PTR_W:0] AF_LEVEL = (PTR_W + 1)'(`FU_QUEUE_DEPTH - 1);

    // entry storage, one array per field
    logic [`XLEN-1:0]    opa_mem    [`FU_QUEUE_DEPTH];
    logic [`XLEN-1:0]    opb_mem    [`FU_QUEUE_DEPTH];
    fu_pkg::alu_func_e   func_mem   [`FU_QUEUE_DEPTH];
    logic [2:0]          funct3_mem [`FU_QUEUE_DEPTH];
    logic [`XLEN-1:0]    op1_mem    [`FU_QUEUE_DEPTH];
    logic [`XLEN-1:0]    op2_mem    [`FU_QUEUE_DEPTH];
    logic                cond_mem   [`FU_QUEUE_DEPTH];
    logic                uncond_mem [`FU_QUEUE_DEPTH];
    logic [`ROBN_W-1:0]  robn_mem   [`FU_QUEUE_DEPTH];
    logic [`PRN_W-1:0]   prn_mem    [`FU_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;
    logic             pop;

    // drain whenever completion side takes a result
    assign pop     = (count != '0) && avail;
    assign q_valid = pop;

    assign count_next = count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= `FALSE;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count <= count_next;
            // includes this cycle's push, so one slot stays spare
            almost_full <= (count_next >= AF_LEVEL) ? `TRUE : `FALSE;
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            opa_mem[wr_ptr]    <= opa;
            opb_mem[wr_ptr]    <= opb;
            func_mem[wr_ptr]   <= func;
            funct3_mem[wr_ptr] <= funct3;
            op1_mem[wr_ptr]    <= op1;
            op2_mem[wr_ptr]    <= op2;
            cond_mem[wr_ptr]   <= cond_branch;
            uncond_mem[wr_ptr] <= uncond_branch;
            robn_mem[wr_ptr]   <= robn;
            prn_mem[wr_ptr]    <= dest_prn;
        end
    end

    // head entry, read straight out
    assign q_opa           = opa_mem[rd_ptr];
    assign q_opb           = opb_mem[rd_ptr];
    assign q_func          = func_mem[rd_ptr];
    assign q_funct3        = funct3_mem[rd_ptr];
    assign q_op1           = op1_mem[rd_ptr];
    assign q_op2           = op2_mem[rd_ptr];
    assign q_cond_branch   = cond_mem[rd_ptr];
    assign q_uncond_branch = uncond_mem[rd_ptr];
    assign q_robn          = robn_mem[rd_ptr];
    assign q_dest_prn      = prn_mem[rd_ptr];

    // issuer must honour almost_full
    a_no_push_full: assert property (@(posedge clock) disable iff (rst)
        push && (count == FULL_LEVEL) |-> pop)
    else $error("issue_queue: push into full queue");

    a_count_bound: assert property (@(posedge clock) disable iff (rst)
        count <= FULL_LEVEL)
    else $error("issue_queue: count above depth");

endmodule

// File: alu.sv
`timescale 1ns/100ps
`include "fu_defines.svh"

module alu (
    input  logic [`XLEN-1:0]  opa,
    input  logic [`XLEN-1:0]  opb,
    input  fu_pkg::alu_func_e func,
    output logic [`XLEN-1:0]  result
);

    logic signed [`XLEN-1:0] s_opa;
    logic signed [`XLEN-1:0] s_opb;
    // RV32 takes shift amount from low 5 bits only
    logic [4:0]              shamt;

    assign s_opa = opa;
    assign s_opb = opb;
    assign shamt = opb[4:0];

    always_comb begin
        case (func)
            fu_pkg::ALU_ADD: begin
                result = opa + opb;
            end
            fu_pkg::ALU_SUB: begin
                result = opa - opb;
            end
            fu_pkg::ALU_AND: begin
                result = opa & opb;
            end
            // set-less-than, 0 or 1
            fu_pkg::ALU_SLT: begin
                result = {{(`XLEN - 1){1'b0}}, s_opa < s_opb};
            end
            fu_pkg::ALU_SLTU: begin
                result = {{(`XLEN - 1){1'b0}}, opa < opb};
            end
            fu_pkg::ALU_OR: begin
                result = opa | opb;
            end
            fu_pkg::ALU_XOR: begin
                result = opa ^ opb;
            end
            fu_pkg::ALU_SRL: begin
                result = opa >> shamt;
            end
            fu_pkg::ALU_SLL: begin
                result = opa << shamt;
            end
            // arithmetic, sign bit fills from the top
            fu_pkg::ALU_SRA: begin
                result = s_opa >>> shamt;
            end
            default: begin
                result = `ALU_BAD_MARK;
            end
        endcase
    end

endmodule

// File: alu_exec.sv
`timescale 1ns/100ps
`include "fu_defines.svh"

module alu_exec (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  q_valid,
    input  logic [`XLEN-1:0]      opa,
    input  logic [`XLEN-1:0]      opb,
    input  fu_pkg::alu_func_e     func,
    input  logic [2:0]            funct3,
    input  logic [`XLEN-1:0]      op1,
    input  logic [`XLEN-1:0]      op2,
    input  logic                  cond_branch,
    input  logic                  uncond_branch,
    input  logic [`ROBN_W-1:0]    robn,
    input  logic [`PRN_W-1:0]     dest_prn,
    output logic                  prepared,
    output logic [`XLEN-1:0]      result,
    output logic [`ROBN_W-1:0]    out_robn,
    output logic [`PRN_W-1:0]     out_dest_prn,
    output logic                  take_branch,
    output logic                  branch_executed,
    output logic [`XLEN-1:0]      target_addr
);

    logic [`XLEN-1:0]        alu_result;
    logic signed [`XLEN-1:0] s_op1;
    logic signed [`XLEN-1:0] s_op2;
    logic                    cond_true;
    logic                    take_now;
    // kept for the branch-kind check only
    logic                    uncond_q;

    // branch target for B/J ops comes out of the ALU as PC + imm
    alu alu_inst (
        .opa    (opa),
        .opb    (opb),
        .func   (func),
        .result (alu_result)
    );

    assign s_op1 = op1;
    assign s_op2 = op2;

    // branch condition on the raw register values
    always_comb begin
        case (funct3)
            3'b000:  cond_true = (op1 == op2);
            3'b001:  cond_true = (op1 != op2);
            3'b100:  cond_true = (s_op1 < s_op2);
            3'b101:  cond_true = (s_op1 >= s_op2);
            3'b110:  cond_true = (op1 < op2);
            3'b111:  cond_true = (op1 >= op2);
            default: cond_true = `FALSE;
        endcase
    end

    assign take_now = uncond_branch || (cond_branch && cond_true);

    // completion strobe and branch record
    always_ff @(posedge clock) begin
        if (rst) begin
            prepared        <= `FALSE;
            take_branch     <= `FALSE;
            branch_executed <= `FALSE;
        end else begin
            prepared        <= q_valid;
            take_branch     <= q_valid && take_now;
            branch_executed <= q_valid && cond_branch;
        end
    end

    // result and tags, only loaded on a pop
    always_ff @(posedge clock) begin
        if (q_valid) begin
            result       <= alu_result;
            out_robn     <= robn;
            out_dest_prn <= dest_prn;
            uncond_q     <= uncond_branch;
        end
    end

    assign target_addr = result;

    // an op is either a conditional or an unconditional branch, never both
    a_branch_kind: assert property (@(posedge clock) disable iff (rst)
        prepared |-> !(branch_executed && uncond_q))
    else $error("alu_exec: op flagged cond and uncond branch");

endmodule

// File: fu_top.sv
`timescale 1ns/100ps
`include "fu_defines.svh"

module fu_top (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  valid,
    input  logic [`XLEN-1:0]      inst,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      op1,
    input  logic [`XLEN-1:0]      op2,
    input  fu_pkg::alu_func_e     func,
    input  fu_pkg::opa_select_e   opa_select,
    input  fu_pkg::opb_select_e   opb_select,
    input  logic                  cond_branch,
    input  logic                  uncond_branch,
    input  logic [`ROBN_W-1:0]    robn,
    input  logic [`PRN_W-1:0]     dest_prn,
    input  logic                  avail,
    output logic                  prepared,
    output logic [`XLEN-1:0]      result,
    output logic [`ROBN_W-1:0]    out_robn,
    output logic [`PRN_W-1:0]     out_dest_prn,
    output logic                  take_branch,
    output logic                  branch_executed,
    output logic [`XLEN-1:0]      target_addr,
    output logic                  almost_full
);

    // producer to queue
    logic                  sel_valid;
    logic [`XLEN-1:0]      sel_opa;
    logic [`XLEN-1:0]      sel_opb;
    fu_pkg::alu_func_e     sel_func;
    logic [2:0]            sel_funct3;
    logic [`XLEN-1:0]      sel_op1;
    logic [`XLEN-1:0]      sel_op2;
    logic                  sel_cond;
    logic                  sel_uncond;
    logic [`ROBN_W-1:0]    sel_robn;
    logic [`PRN_W-1:0]     sel_dest_prn;

    // queue head to consumer
    logic                  q_valid;
    logic [`XLEN-1:0]      q_opa;
    logic [`XLEN-1:0]      q_opb;
    fu_pkg::alu_func_e     q_func;
    logic [2:0]            q_funct3;
    logic [`XLEN-1:0]      q_op1;
    logic [`XLEN-1:0]      q_op2;
    logic                  q_cond;
    logic                  q_uncond;
    logic [`ROBN_W-1:0]    q_robn;
    logic [`PRN_W-1:0]     q_dest_prn;

    operand_select operand_select_inst (
        .valid         (valid),
        .inst          (inst),
        .pc            (pc),
        .op1           (op1),
        .op2           (op2),
        .func          (func),
        .opa_select    (opa_select),
        .opb_select    (opb_select),
        .cond_branch   (cond_branch),
        .uncond_branch (uncond_branch),
        .robn          (robn),
        .dest_prn      (dest_prn),
        .sel_valid     (sel_valid),
        .opa           (sel_opa),
        .opb           (sel_opb),
        .func_out      (sel_func),
        .funct3        (sel_funct3),
        .op1_out       (sel_op1),
        .op2_out       (sel_op2),
        .cond_out      (sel_cond),
        .uncond_out    (sel_uncond),
        .robn_out      (sel_robn),
        .dest_prn_out  (sel_dest_prn)
    );

    issue_queue issue_queue_inst (
        .clock           (clock),
        .rst             (rst),
        .push            (sel_valid),
        .opa             (sel_opa),
        .opb             (sel_opb),
        .func            (sel_func),
        .funct3          (sel_funct3),
        .op1             (sel_op1),
        .op2             (sel_op2),
        .cond_branch     (sel_cond),
        .uncond_branch   (sel_uncond),
        .robn            (sel_robn),
        .dest_prn        (sel_dest_prn),
        .avail           (avail),
        .q_valid         (q_valid),
        .q_opa           (q_opa),
        .q_opb           (q_opb),
        .q_func          (q_func),
        .q_funct3        (q_funct3),
        .q_op1           (q_op1),
        .q_op2           (q_op2),
        .q_cond_branch   (q_cond),
        .q_uncond_branch (q_uncond),
        .q_robn          (q_robn),
        .q_dest_prn      (q_dest_prn),
        .almost_full     (almost_full)
    );

    alu_exec alu_exec_inst (
        .clock           (clock),
        .rst             (rst),
        .q_valid         (q_valid),
        .opa             (q_opa),
        .opb             (q_opb),
        .func            (q_func),
        .funct3          (q_funct3),
        .op1             (q_op1),
        .op2             (q_op2),
        .cond_branch     (q_cond),
        .uncond_branch   (q_uncond),
        .robn            (q_robn),
        .dest_prn        (q_dest_prn),
        .prepared        (prepared),
        .result          (result),
        .out_robn        (out_robn),
        .out_dest_prn    (out_dest_prn),
        .take_branch     (take_branch),
        .branch_executed (branch_executed),
        .target_addr     (target_addr)
    );

endmodule

// File: tb_fu_top.sv
`timescale 1ns/100ps
`include "fu_defines.svh"

module tb_fu_top;

    // operation counts per phase
    localparam int N_ALU = 200;
    localparam int N_IMM = 100;
    localparam int N_BR = 120;
    localparam int N_MIX = 200;
    localparam int NUM_OPS = 3 + N_ALU + N_IMM + N_BR + N_MIX;
    localparam int CYCLE_LIMIT = 8 * NUM_OPS + 200;

    // one outstanding result as the ROB would see it
    typedef struct packed {
        logic [`XLEN-1:0]   result;
        logic               take;
        logic               bexec;
        logic [`ROBN_W-1:0] robn;
        logic [`PRN_W-1:0]  prn;
    } expect_s;

    logic                clock;
    logic                rst;
    logic                valid;
    logic [`XLEN-1:0]    inst;
    logic [`XLEN-1:0]    pc;
    logic [`XLEN-1:0]    op1;
    logic [`XLEN-1:0]    op2;
    fu_pkg::alu_func_e   func;
    fu_pkg::opa_select_e opa_select;
    fu_pkg::opb_select_e opb_select;
    logic                cond_branch;
    logic                uncond_branch;
    logic [`ROBN_W-1:0]  robn;
    logic [`PRN_W-1:0]   dest_prn;
    logic                avail;
    logic                prepared;
    logic [`XLEN-1:0]    result;
    logic [`ROBN_W-1:0]  out_robn;
    logic [`PRN_W-1:0]   out_dest_prn;
    logic                take_branch;
    logic                branch_executed;
    logic [`XLEN-1:0]    target_addr;
    logic                almost_full;

    logic [31:0] seed;
    expect_s     exp_q[$];
    int          op_count;
    // 0 holds avail low, 1 high, 2 random
    int          avail_mode;
    logic        avail_at_edge;
    int          cycle_count = 0;

    fu_top fu_top_inst (
        .clock           (clock),
        .rst             (rst),
        .valid           (valid),
        .inst            (inst),
        .pc              (pc),
        .op1             (op1),
        .op2             (op2),
        .func            (func),
        .opa_select      (opa_select),
        .opb_select      (opb_select),
        .cond_branch     (cond_branch),
        .uncond_branch   (uncond_branch),
        .robn            (robn),
        .dest_prn        (dest_prn),
        .avail           (avail),
        .prepared        (prepared),
        .result          (result),
        .out_robn        (out_robn),
        .out_dest_prn    (out_dest_prn),
        .take_branch     (take_branch),
        .branch_executed (branch_executed),
        .target_addr     (target_addr),
        .almost_full     (almost_full)
    );

    // 8 ns period
    always #4 clock = ~clock;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // low LCG bits cycle fast, so use the upper ones
    function automatic int unsigned rand_below(input int unsigned n);
        return (lcg_next() >> 8) % n;
    endfunction

    // expected {take_branch, result} straight from the RV32I rules
    function automatic logic [32:0] ref_model(
        input logic [31:0]         w,
        input logic [31:0]         pc_v,
        input logic [31:0]         a,
        input logic [31:0]         b,
        input fu_pkg::alu_func_e   f,
        input fu_pkg::opa_select_e sa,
        input fu_pkg::opb_select_e sb,
        input logic                c,
        input logic                u
    );
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] r;
        logic        hit;
        case (sa)
            fu_pkg::OPA_IS_PC:   x = pc_v;
            fu_pkg::OPA_IS_ZERO: x = 32'h0;
            default:             x = a;
        endcase
        // immediate layouts as in the ISA manual
        case (sb)
            fu_pkg::OPB_IS_I_IMM: y = {{20{w[31]}}, w[31:20]};
            fu_pkg::OPB_IS_S_IMM: y = {{20{w[31]}}, w[31:25], w[11:7]};
            fu_pkg::OPB_IS_B_IMM: y = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            fu_pkg::OPB_IS_U_IMM: y = {w[31:12], 12'h000};
            fu_pkg::OPB_IS_J_IMM: y = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:              y = b;
        endcase
        case (f)
            fu_pkg::ALU_ADD:  r = x + y;
            fu_pkg::ALU_SUB:  r = x - y;
            fu_pkg::ALU_AND:  r = x & y;
            fu_pkg::ALU_SLT:  r = {31'h0, $signed(x) < $signed(y)};
            fu_pkg::ALU_SLTU: r = {31'h0, x < y};
            fu_pkg::ALU_OR:   r = x | y;
            fu_pkg::ALU_XOR:  r = x ^ y;
            fu_pkg::ALU_SRL:  r = x >> y[4:0];
            fu_pkg::ALU_SLL:  r = x << y[4:0];
            default:          r = $signed(x) >>> y[4:0];
        endcase
        // branch compare always on the register values
        case (w[14:12])
            3'b000:  hit = (a == b);
            3'b001:  hit = (a != b);
            3'b100:  hit = ($signed(a) < $signed(b));
            3'b101:  hit = ($signed(a) >= $signed(b));
            3'b110:  hit = (a < b);
            3'b111:  hit = (a >= b);
            default: hit = 1'b0;
        endcase
        return {u | (c & hit), r};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    // quiet outputs during and just after reset
    task automatic expect_idle();
        check_value("prepared", 32'h0, 32'(prepared));
        check_value("take_branch", 32'h0, 32'(take_branch));
        check_value("branch_executed", 32'h0, 32'(branch_executed));
        check_value("almost_full", 32'h0, 32'(almost_full));
    endtask

    // next falling edge, then the avail level for the coming cycle
    task automatic step_cycle();
        @(negedge clock);
        case (avail_mode)
            0:       avail = 1'b0;
            1:       avail = 1'b1;
            default: avail = 1'(rand_below(2));
        endcase
    endtask

    task automatic issue_op(
        input logic [31:0]         inst_v,
        input logic [31:0]         pc_v,
        input logic [31:0]         a,
        input logic [31:0]         b,
        input fu_pkg::alu_func_e   f,
        input fu_pkg::opa_select_e sa,
        input fu_pkg::opb_select_e sb,
        input logic                c,
        input logic                u
    );
        logic [32:0] ref_out;
        expect_s     e;
        // hold off while the queue is close to full
        while (almost_full) begin
            step_cycle();
        end
        ref_out = ref_model(inst_v, pc_v, a, b, f, sa, sb, c, u);
        e.result = ref_out[31:0];
        e.take = ref_out[32];
        e.bexec = c;
        e.robn = `ROBN_W'(op_count);
        e.prn = `PRN_W'(lcg_next() >> 7);
        inst = inst_v;
        pc = pc_v;
        op1 = a;
        op2 = b;
        func = f;
        opa_select = sa;
        opb_select = sb;
        cond_branch = c;
        uncond_branch = u;
        robn = e.robn;
        dest_prn = e.prn;
        valid = 1'b1;
        exp_q.push_back(e);
        op_count++;
        step_cycle();
        valid = 1'b0;
    endtask

    // kind 0 reg-reg ALU, 1 immediates, 2 cond branch, 3 jump
    task automatic send_random(input int kind, input int seq);
        fu_pkg::inst_u       iw;
        logic [31:0]         pc_v;
        logic [31:0]         a;
        logic [31:0]         b;
        fu_pkg::alu_func_e   f;
        fu_pkg::opa_select_e sa;
        fu_pkg::opb_select_e sb;
        logic                c;
        logic                u;
        iw.f.opcode = 7'h33;
        iw.f.rd = 5'(rand_below(32));
        iw.f.funct3 = 3'(rand_below(8));
        iw.f.rs1 = 5'(rand_below(32));
        iw.f.rs2 = 5'(rand_below(32));
        iw.f.funct7 = 7'(rand_below(128));
        pc_v = lcg_next() & 32'hffff_fffc;
        a = lcg_next();
        // upper bits set here also exercise shift amounts above 31
        b = lcg_next();
        f = fu_pkg::alu_func_e'(4'(seq % 10));
        sa = fu_pkg::OPA_IS_RS1;
        sb = fu_pkg::OPB_IS_RS2;
        c = 1'b0;
        u = 1'b0;
        case (kind)
            1: begin
                iw.f.opcode = 7'h13;
                f = fu_pkg::alu_func_e'(4'(rand_below(10)));
                sa = fu_pkg::opa_select_e'(2'(rand_below(3)));
                sb = fu_pkg::opb_select_e'(3'(1 + rand_below(5)));
            end
            2: begin
                iw.f.opcode = 7'h63;
                // equal operands often enough for beq and bge
                if (rand_below(4) == 0) begin
                    b = a;
                end
                f = fu_pkg::ALU_ADD;
                sa = fu_pkg::OPA_IS_PC;
                sb = fu_pkg::OPB_IS_B_IMM;
                c = 1'b1;
            end
            3: begin
                iw.f.opcode = 7'h6f;
                f = fu_pkg::ALU_ADD;
                sa = fu_pkg::OPA_IS_PC;
                sb = fu_pkg::OPB_IS_J_IMM;
                u = 1'b1;
            end
            default: begin
            end
        endcase
        issue_op(iw, pc_v, a, b, f, sa, sb, c, u);
    endtask

    // avail level of the cycle that just closed
    always @(posedge clock) begin
        avail_at_edge <= avail;
    end

    // compare every completion against the oldest expected entry
    always @(negedge clock) begin : compare_proc
        expect_s head;
        if (!rst && prepared) begin
            if (!avail_at_edge) begin
                $display("prepared went high at %0t ns while avail was low", $time);
                $display("Done: errors found");
                $fatal(1, "completion without avail");
            end else if (exp_q.size() == 0) begin
                $display("prepared went high at %0t ns with no operation outstanding", $time);
                $display("Done: errors found");
                $fatal(1, "unexpected completion");
            end else begin
                head = exp_q.pop_front();
                check_value("result", head.result, result);
                check_value("target_addr", head.result, target_addr);
                check_value("out_robn", 32'(head.robn), 32'(out_robn));
                check_value("out_dest_prn", 32'(head.prn), 32'(out_dest_prn));
                check_value("take_branch", 32'(head.take), 32'(take_branch));
                check_value("branch_executed", 32'(head.bexec), 32'(branch_executed));
            end
        end
    end

    // run length guard
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed = 32'd76;
        clock = 1'b0;
        rst = 1'b1;
        valid = 1'b0;
        inst = '0;
        pc = '0;
        op1 = '0;
        op2 = '0;
        func = fu_pkg::ALU_ADD;
        opa_select = fu_pkg::OPA_IS_RS1;
        opb_select = fu_pkg::OPB_IS_RS2;
        cond_branch = 1'b0;
        uncond_branch = 1'b0;
        robn = '0;
        dest_prn = '0;
        avail = 1'b0;
        avail_mode = 0;
        op_count = 0;

        // reset for 3 cycles
        repeat (3) begin
            @(negedge clock);
            expect_idle();
        end
        rst = 1'b0;
        step_cycle();
        expect_idle();

        // fill with avail low, almost_full after depth-1 pushes
        for (int i = 0; i < `FU_QUEUE_DEPTH - 1; i++) begin
            send_random(0, i);
            check_value("almost_full", (i == `FU_QUEUE_DEPTH - 2) ? 32'h1 : 32'h0,
                        32'(almost_full));
        end
        // nothing may complete while avail stays low
        repeat (6) step_cycle();

        avail_mode = 1;
        for (int i = 0; i < N_ALU; i++) begin
            send_random(0, i);
        end
        for (int i = 0; i < N_IMM; i++) begin
            send_random(1, i);
        end
        for (int i = 0; i < N_BR; i++) begin
            send_random((i % 4 == 3) ? 3 : 2, i);
        end

        // random back-pressure, mixed ops, occasional idle gaps
        avail_mode = 2;
        for (int i = 0; i < N_MIX; i++) begin
            send_random(int'(rand_below(4)), i);
            if (rand_below(3) == 0) begin
                step_cycle();
            end
        end

        // drain the queue, a few cycles per entry at most with avail high
        avail_mode = 1;
        for (int i = 0; i < 4 * `FU_QUEUE_DEPTH && exp_q.size() != 0; i++) begin
            step_cycle();
        end
        repeat (4) step_cycle();

        if (exp_q.size() != 0) begin
            $display("run ended with %0d results never completed", exp_q.size());
            $display("Done: errors found");
            $fatal(1, "missing completions");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: sources.f
+incdir+.
fu_pkg.sv
operand_select.sv
issue_queue.sv
alu.sv
alu_exec.sv
fu_top.sv
tb_fu_top.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f \
    --top-module tb_fu_top -o tb_fu_top_sim &&
./obj_dir/tb_fu_top_sim | grep -F "Done: no errors" &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}
